/* led_calib_top.f */
source/led_calib_pkg.sv
source/led_mem_pkg.sv
source/led_request_scan.sv
source/led_id_pattern.sv
source/frame_mem_arbiter.sv
source/frame_ram.sv
source/led_calib_top.sv
test/led_calib_properties.sv
test/led_calib_checker.sv
test/led_calib_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the LED calibration testbench with Verilator and runs it

set -u
cd "$(dirname "$0")" || exit 1

build_dir=obj_dir

verilator --binary --timing --assert -f led_calib_top.f \
    --top-module led_calib_tb -Mdir "$build_dir"
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$("$build_dir/Vled_calib_tb")
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "TESTS PASSED"; then
    exit 0
fi
exit 1

/* source/frame_mem_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module frame_mem_arbiter #(
    parameter int NUM_LEDS = 50
) (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic                                  host_valid,
    output logic                                  host_ready,
    input  logic [INDEX_WIDTH-1:0]                host_addr,
    input  logic [led_calib_pkg::color_width-1:0] host_color,
    input  logic                                  rd_valid,
    output logic                                  rd_ready,
    input  logic [INDEX_WIDTH-1:0]                rd_addr,
    output logic                                  rd_data_valid,
    output logic [led_calib_pkg::color_width-1:0] rd_data,
    output logic                                  mem_en,
    output led_mem_pkg::mem_op_e                  mem_op,
    output logic [INDEX_WIDTH-1:0]                mem_addr,
    output logic [led_calib_pkg::color_width-1:0] mem_wdata,
    input  logic [led_calib_pkg::color_width-1:0] mem_rdata
);
    localparam int INDEX_WIDTH = $clog2(NUM_LEDS);

    led_mem_pkg::mem_client_e last_served;
    logic                     grant_host;
    logic                     grant_rd;

    // On a tie the peer that was not served last time goes first
    assign grant_host = host_valid &&
                        (!rd_valid || last_served == led_mem_pkg::CLIENT_PATTERN);
    assign grant_rd   = rd_valid && !grant_host;

    assign host_ready = grant_host;
    assign rd_ready   = grant_rd;

    assign mem_en    = grant_host || grant_rd;
    assign mem_op    = grant_host ? led_mem_pkg::OP_WRITE : led_mem_pkg::OP_READ;
    assign mem_addr  = grant_host ? host_addr : rd_addr;
    assign mem_wdata = host_color;
    assign rd_data   = mem_rdata;

    always_ff @(posedge clk) begin
        if (rst) begin
            last_served   <= led_mem_pkg::CLIENT_PATTERN;
            rd_data_valid <= 1'b0;
        end else begin
            // RAM answers a read one cycle after the grant
            rd_data_valid <= grant_rd;
            if (grant_host) begin
                last_served <= led_mem_pkg::CLIENT_HOST;
            end else if (grant_rd) begin
                last_served <= led_mem_pkg::CLIENT_PATTERN;
            end
        end
    end

endmodule

`default_nettype wire

/* source/frame_ram.sv */
`timescale 1ns/1ps
`default_nettype none

module frame_ram #(
    parameter int NUM_LEDS = 50
) (
    input  logic                                  clk,
    input  logic                                  mem_en,
    input  led_mem_pkg::mem_op_e                  mem_op,
    input  logic [INDEX_WIDTH-1:0]                mem_addr,
    input  logic [led_calib_pkg::color_width-1:0] mem_wdata,
    output logic [led_calib_pkg::color_width-1:0] mem_rdata
);
    localparam int INDEX_WIDTH = $clog2(NUM_LEDS);

    logic [led_calib_pkg::color_width-1:0] mem [NUM_LEDS];

    // Unwritten LEDs read back as black
    initial begin
        for (int i = 0; i < NUM_LEDS; i++) begin
            mem[i] = '0;
        end
    end

    // Read-first, a write returns the old word
    always_ff @(posedge clk) begin
        if (mem_en) begin
            mem_rdata <= mem[mem_addr];
            if (mem_op == led_mem_pkg::OP_WRITE) begin
                mem[mem_addr] <= mem_wdata;
            end
        end
    end

endmodule

`default_nettype wire

/* source/led_calib_pkg.sv */
package led_calib_pkg;

    // One RGB colour, 8 bits per channel
    localparam int color_width = 24;

    typedef enum logic [1:0] {
        MODE_ID_BITS = 2'd0,
        MODE_STORED  = 2'd1,
        MODE_OFF     = 2'd2
    } display_mode_e;

    // Index bit 0 shows red, index bit 1 shows blue
    localparam logic [color_width-1:0] color_bit_zero = 24'hFF0000;
    localparam logic [color_width-1:0] color_bit_one  = 24'h0000FF;
    localparam logic [color_width-1:0] color_off      = 24'h000000;

    typedef enum logic [1:0] {
        IDLE,
        SHIFT,
        MEM_WAIT,
        HOLD
    } pattern_state_e;

endpackage

/* source/led_calib_top.sv */
`timescale 1ns/1ps
`default_nettype none

module led_calib_top #(
    parameter int NUM_LEDS = 50
) (
    input  logic                                  clk,
    input  logic                                  rst,
    input  led_calib_pkg::display_mode_e          mode,
    input  logic [INDEX_WIDTH-1:0]                bit_sel,
    input  logic                                  host_valid,
    output logic                                  host_ready,
    input  logic [INDEX_WIDTH-1:0]                host_addr,
    input  logic [led_calib_pkg::color_width-1:0] host_color,
    output logic                                  color_valid,
    input  logic                                  color_ready,
    output logic [INDEX_WIDTH-1:0]                color_index,
    output logic [led_calib_pkg::color_width-1:0] color_rgb,
    output logic                                  frame_valid
);
    localparam int INDEX_WIDTH = $clog2(NUM_LEDS);

    // Scan to pattern
    logic                                  req_valid;
    logic                                  req_ready;
    logic [INDEX_WIDTH-1:0]                req_index;

    // Pattern to arbiter
    logic                                  rd_valid;
    logic                                  rd_ready;
    logic [INDEX_WIDTH-1:0]                rd_addr;
    logic                                  rd_data_valid;
    logic [led_calib_pkg::color_width-1:0] rd_data;

    // Arbiter to RAM
    logic                                  mem_en;
    led_mem_pkg::mem_op_e                  mem_op;
    logic [INDEX_WIDTH-1:0]                mem_addr;
    logic [led_calib_pkg::color_width-1:0] mem_wdata;
    logic [led_calib_pkg::color_width-1:0] mem_rdata;

    led_request_scan #(
        .NUM_LEDS(NUM_LEDS)
    ) led_request_scan_i (
        .clk       (clk),
        .rst       (rst),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .req_index (req_index)
    );

    led_id_pattern #(
        .NUM_LEDS(NUM_LEDS)
    ) led_id_pattern_i (
        .clk           (clk),
        .rst           (rst),
        .mode          (mode),
        .bit_sel       (bit_sel),
        .req_valid     (req_valid),
        .req_ready     (req_ready),
        .req_index     (req_index),
        .rd_valid      (rd_valid),
        .rd_ready      (rd_ready),
        .rd_addr       (rd_addr),
        .rd_data_valid (rd_data_valid),
        .rd_data       (rd_data),
        .color_valid   (color_valid),
        .color_ready   (color_ready),
        .color_index   (color_index),
        .color_rgb     (color_rgb),
        .frame_valid   (frame_valid)
    );

    frame_mem_arbiter #(
        .NUM_LEDS(NUM_LEDS)
    ) frame_mem_arbiter_i (
        .clk           (clk),
        .rst           (rst),
        .host_valid    (host_valid),
        .host_ready    (host_ready),
        .host_addr     (host_addr),
        .host_color    (host_color),
        .rd_valid      (rd_valid),
        .rd_ready      (rd_ready),
        .rd_addr       (rd_addr),
        .rd_data_valid (rd_data_valid),
        .rd_data       (rd_data),
        .mem_en        (mem_en),
        .mem_op        (mem_op),
        .mem_addr      (mem_addr),
        .mem_wdata     (mem_wdata),
        .mem_rdata     (mem_rdata)
    );

    frame_ram #(
        .NUM_LEDS(NUM_LEDS)
    ) frame_ram_i (
        .clk       (clk),
        .mem_en    (mem_en),
        .mem_op    (mem_op),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_rdata (mem_rdata)
    );

endmodule

`default_nettype wire

/* source/led_id_pattern.sv */
`timescale 1ns/1ps
`default_nettype none

module led_id_pattern #(
    parameter int NUM_LEDS = 50
) (
    input  logic                                  clk,
    input  logic                                  rst,
    input  led_calib_pkg::display_mode_e          mode,
    input  logic [INDEX_WIDTH-1:0]                bit_sel,
    input  logic                                  req_valid,
    output logic                                  req_ready,
    input  logic [INDEX_WIDTH-1:0]                req_index,
    output logic                                  rd_valid,
    input  logic                                  rd_ready,
    output logic [INDEX_WIDTH-1:0]                rd_addr,
    input  logic                                  rd_data_valid,
    input  logic [led_calib_pkg::color_width-1:0] rd_data,
    output logic                                  color_valid,
    input  logic                                  color_ready,
    output logic [INDEX_WIDTH-1:0]                color_index,
    output logic [led_calib_pkg::color_width-1:0] color_rgb,
    output logic                                  frame_valid
);
    localparam int INDEX_WIDTH = $clog2(NUM_LEDS);

    led_calib_pkg::pattern_state_e state;
    led_calib_pkg::display_mode_e  prev_mode;
    logic [INDEX_WIDTH-1:0]        prev_bit_sel;
    logic [INDEX_WIDTH-1:0]        shift_reg;
    logic [INDEX_WIDTH-1:0]        shift_cnt;
    logic [1:0]                    zero_count;
    logic                          accept;
    logic                          settings_changed;

    function automatic logic [led_calib_pkg::color_width-1:0] bit_color(input logic b);
        return b ? led_calib_pkg::color_bit_one : led_calib_pkg::color_bit_zero;
    endfunction

    assign req_ready        = (state == led_calib_pkg::IDLE);
    assign accept           = req_valid && req_ready;
    assign settings_changed = (mode != prev_mode) || (bit_sel != prev_bit_sel);

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= led_calib_pkg::IDLE;
            color_valid <= 1'b0;
            rd_valid    <= 1'b0;
        end else begin
            case (state)
                led_calib_pkg::IDLE: begin
                    if (accept) begin
                        color_index <= req_index;
                        case (mode)
                            led_calib_pkg::MODE_ID_BITS: begin
                                // Bit 0 needs no shift, answer right away
                                if (bit_sel == '0) begin
                                    color_rgb   <= bit_color(req_index[0]);
                                    color_valid <= 1'b1;
                                    state       <= led_calib_pkg::HOLD;
                                end else begin
                                    shift_reg <= req_index >> 1;
                                    shift_cnt <= INDEX_WIDTH'(1);
                                    state     <= led_calib_pkg::SHIFT;
                                end
                            end
                            led_calib_pkg::MODE_STORED: begin
                                rd_valid <= 1'b1;
                                rd_addr  <= req_index;
                                state    <= led_calib_pkg::MEM_WAIT;
                            end
                            default: begin
                                color_rgb   <= led_calib_pkg::color_off;
                                color_valid <= 1'b1;
                                state       <= led_calib_pkg::HOLD;
                            end
                        endcase
                    end
                end
                led_calib_pkg::SHIFT: begin
                    // One bit per cycle until the selected bit sits at the bottom
                    if (shift_cnt >= bit_sel) begin
                        color_rgb   <= bit_color(shift_reg[0]);
                        color_valid <= 1'b1;
                        state       <= led_calib_pkg::HOLD;
                    end else begin
                        shift_reg <= shift_reg >> 1;
                        shift_cnt <= shift_cnt + 1'b1;
                    end
                end
                led_calib_pkg::MEM_WAIT: begin
                    if (rd_valid && rd_ready) begin
                        rd_valid <= 1'b0;
                    end
                    if (rd_data_valid) begin
                        color_rgb   <= rd_data;
                        color_valid <= 1'b1;
                        state       <= led_calib_pkg::HOLD;
                    end
                end
                default: begin
                    if (color_ready) begin
                        color_valid <= 1'b0;
                        state       <= led_calib_pkg::IDLE;
                    end
                end
            endcase
        end
    end

    // A frame counts as shown after index 0 went in twice with unchanged settings
    always_ff @(posedge clk) begin
        if (rst) begin
            prev_mode    <= mode;
            prev_bit_sel <= bit_sel;
            zero_count   <= 2'd0;
            frame_valid  <= 1'b0;
        end else begin
            prev_mode    <= mode;
            prev_bit_sel <= bit_sel;
            if (settings_changed) begin
                zero_count  <= 2'd0;
                frame_valid <= 1'b0;
            end else if (accept && req_index == '0 && zero_count != 2'd2) begin
                zero_count <= zero_count + 1'b1;
                if (zero_count == 2'd1) begin
                    frame_valid <= 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* source/led_mem_pkg.sv */
package led_mem_pkg;

    // Operation on the shared frame memory port
    typedef enum logic {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } mem_op_e;

    // Peers that share the frame memory
    typedef enum logic {
        CLIENT_HOST    = 1'b0,
        CLIENT_PATTERN = 1'b1
    } mem_client_e;

endpackage

/* source/led_request_scan.sv */
`timescale 1ns/1ps
`default_nettype none

module led_request_scan #(
    parameter int NUM_LEDS = 50
) (
    input  logic                   clk,
    input  logic                   rst,
    output logic                   req_valid,
    input  logic                   req_ready,
    output logic [INDEX_WIDTH-1:0] req_index
);
    localparam int INDEX_WIDTH = $clog2(NUM_LEDS);
    localparam logic [INDEX_WIDTH-1:0] LAST_INDEX = INDEX_WIDTH'(NUM_LEDS - 1);

    // Pixel walk of the strip, one index per accepted transfer
    always_ff @(posedge clk) begin
        if (rst) begin
            req_valid <= 1'b0;
            req_index <= '0;
        end else begin
            req_valid <= 1'b1;
            if (req_valid && req_ready) begin
                if (req_index == LAST_INDEX) begin
                    req_index <= '0;
                end else begin
                    req_index <= req_index + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* test/led_calib_checker.sv */
`timescale 1ns/1ps

module led_calib_checker #(
    parameter int NUM_LEDS = 50
) (
    input  logic                                  clk,
    input  logic                                  rst,
    input  led_calib_pkg::display_mode_e          mode,
    input  logic [$clog2(NUM_LEDS)-1:0]           bit_sel,
    input  logic                                  host_valid,
    input  logic                                  host_ready,
    input  logic [$clog2(NUM_LEDS)-1:0]           host_addr,
    input  logic [led_calib_pkg::color_width-1:0] host_color,
    input  logic                                  color_valid,
    input  logic                                  color_ready,
    input  logic [$clog2(NUM_LEDS)-1:0]           color_index,
    input  logic [led_calib_pkg::color_width-1:0] color_rgb,
    input  logic                                  frame_valid,
    input  logic                                  test_end,
    input  logic                                  exp_frame_valid,
    output int                                    xfer_count,
    output int                                    error_count
);
    localparam int INDEX_WIDTH = $clog2(NUM_LEDS);
    localparam logic [INDEX_WIDTH-1:0] LAST_INDEX = INDEX_WIDTH'(NUM_LEDS - 1);

    logic [led_calib_pkg::color_width-1:0] model [NUM_LEDS];
    logic [led_calib_pkg::color_width-1:0] expected_rgb;
    logic [led_calib_pkg::color_width-1:0] pend_color;
    logic [INDEX_WIDTH-1:0]                pend_addr;
    logic [INDEX_WIDTH-1:0]                next_index;
    logic [INDEX_WIDTH-1:0]                shifted;
    logic [INDEX_WIDTH-1:0]                last_bit_sel;
    led_calib_pkg::display_mode_e          last_mode;
    logic                                  pend_valid;
    logic                                  have_capture;
    logic                                  fv_low_pending;
    int                                    gen;
    int                                    cap_gen;
    int                                    zero_seen;

    task automatic report(input string signal, input logic [31:0] expected,
                          input logic [31:0] actual);
        error_count++;
        $display("CHECK FAILED time=%0t signal=%s expected=%h actual=%h",
                 $time, signal, expected, actual);
    endtask

    always @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_LEDS; i++) begin
                model[i] = '0;
            end
            have_capture   = 1'b0;
            fv_low_pending = 1'b0;
            pend_valid     = 1'b0;
            next_index     = '0;
            gen            = 0;
            zero_seen      = 0;
            xfer_count     = 0;
            error_count    = 0;
            last_mode      = mode;
            last_bit_sel   = bit_sel;
        end else begin
            if (fv_low_pending && frame_valid !== 1'b0) begin
                report("frame_valid", 32'd0, 32'(frame_valid));
            end
            fv_low_pending = 1'b0;
            // Any settings change starts a new frame count
            if (mode != last_mode || bit_sel != last_bit_sel) begin
                gen++;
                zero_seen      = 0;
                fv_low_pending = 1'b1;
            end
            last_mode    = mode;
            last_bit_sel = bit_sel;

            // Expected colour is fixed by the settings when the output first appears
            if (color_valid && !have_capture) begin
                have_capture = 1'b1;
                cap_gen      = gen;
                case (mode)
                    led_calib_pkg::MODE_ID_BITS: begin
                        shifted      = color_index >> bit_sel;
                        expected_rgb = shifted[0] ? led_calib_pkg::color_bit_one
                                                  : led_calib_pkg::color_bit_zero;
                    end
                    led_calib_pkg::MODE_STORED: expected_rgb = model[color_index];
                    default: expected_rgb = led_calib_pkg::color_off;
                endcase
            end

            if (color_valid && color_ready) begin
                xfer_count++;
                if (color_rgb !== expected_rgb) begin
                    report("color_rgb", 32'(expected_rgb), 32'(color_rgb));
                end
                if (color_index !== next_index) begin
                    report("color_index", 32'(next_index), 32'(color_index));
                end
                next_index = (color_index == LAST_INDEX) ? '0 : color_index + 1'b1;
                if (cap_gen == gen && color_index == '0) begin
                    zero_seen++;
                    if (zero_seen >= 2 && frame_valid !== 1'b1) begin
                        report("frame_valid", 32'd1, 32'(frame_valid));
                    end
                end
                have_capture = 1'b0;
            end

            // A write lands in the model one sample late, as a read in flight missed it
            if (pend_valid) begin
                model[pend_addr] = pend_color;
            end
            pend_valid = host_valid && host_ready;
            pend_addr  = host_addr;
            pend_color = host_color;

            if (test_end && frame_valid !== exp_frame_valid) begin
                report("frame_valid", 32'(exp_frame_valid), 32'(frame_valid));
            end
        end
    end

endmodule

/* test/led_calib_properties.sv */
`timescale 1ns/1ps

module led_calib_properties #(
    parameter int NUM_LEDS = 50
) (
    input logic                                  clk,
    input logic                                  rst,
    input logic                                  color_valid,
    input logic                                  color_ready,
    input logic [$clog2(NUM_LEDS)-1:0]           color_index,
    input logic [led_calib_pkg::color_width-1:0] color_rgb,
    input logic                                  rd_valid,
    input logic                                  rd_ready,
    input logic [$clog2(NUM_LEDS)-1:0]           rd_addr,
    input logic                                  rd_data_valid,
    input logic                                  mem_en
);

    // A held colour stays put until the strip takes it
    assert property (@(posedge clk) disable iff (rst)
        color_valid && !color_ready |=>
            color_valid && $stable(color_index) && $stable(color_rgb))
        else $error("colour output changed while held under back-pressure");

    // No memory access in the first cycle out of reset
    assert property (@(posedge clk) $past(rst) && !rst |-> !mem_en)
        else $error("mem_en high in the first cycle after reset");

    // Read data comes exactly one cycle after a read grant
    assert property (@(posedge clk) disable iff (rst)
        rd_valid && rd_ready |=> rd_data_valid)
        else $error("rd_data_valid missing one cycle after a read grant");

    // A waiting read request keeps its address until the arbiter grants it
    assert property (@(posedge clk) disable iff (rst)
        rd_valid && !rd_ready |=> rd_valid && $stable(rd_addr))
        else $error("read request dropped or changed before it was granted");

endmodule

bind led_calib_top led_calib_properties #(
    .NUM_LEDS(NUM_LEDS)
) led_calib_properties_i (
    .clk           (clk),
    .rst           (rst),
    .color_valid   (color_valid),
    .color_ready   (color_ready),
    .color_index   (color_index),
    .color_rgb     (color_rgb),
    .rd_valid      (rd_valid),
    .rd_ready      (rd_ready),
    .rd_addr       (rd_addr),
    .rd_data_valid (rd_data_valid),
    .mem_en        (mem_en)
);

/* test/led_calib_tb.sv */
`timescale 1ns/1ps

module led_calib_tb;
    localparam int NUM_LEDS = 50;
    localparam int INDEX_WIDTH = $clog2(NUM_LEDS);
    localparam int WAIT_LIMIT = 500;
    localparam int CYCLES_PER_LED = 40;

    logic                                  clk;
    logic                                  rst;
    led_calib_pkg::display_mode_e          mode;
    logic [INDEX_WIDTH-1:0]                bit_sel;
    logic                                  host_valid;
    logic                                  host_ready;
    logic [INDEX_WIDTH-1:0]                host_addr;
    logic [led_calib_pkg::color_width-1:0] host_color;
    logic                                  color_valid;
    logic                                  color_ready;
    logic [INDEX_WIDTH-1:0]                color_index;
    logic [led_calib_pkg::color_width-1:0] color_rgb;
    logic                                  frame_valid;
    logic                                  test_end;
    logic                                  exp_frame_valid;
    logic                                  hold_ready;
    logic                                  timed_out;
    logic                                  file_error;
    int                                    xfer_count;
    int                                    error_count;

    led_calib_top #(
        .NUM_LEDS(NUM_LEDS)
    ) led_calib_top_i (
        .clk         (clk),
        .rst         (rst),
        .mode        (mode),
        .bit_sel     (bit_sel),
        .host_valid  (host_valid),
        .host_ready  (host_ready),
        .host_addr   (host_addr),
        .host_color  (host_color),
        .color_valid (color_valid),
        .color_ready (color_ready),
        .color_index (color_index),
        .color_rgb   (color_rgb),
        .frame_valid (frame_valid)
    );

    led_calib_checker #(
        .NUM_LEDS(NUM_LEDS)
    ) checker_i (
        .clk             (clk),
        .rst             (rst),
        .mode            (mode),
        .bit_sel         (bit_sel),
        .host_valid      (host_valid),
        .host_ready      (host_ready),
        .host_addr       (host_addr),
        .host_color      (host_color),
        .color_valid     (color_valid),
        .color_ready     (color_ready),
        .color_index     (color_index),
        .color_rgb       (color_rgb),
        .frame_valid     (frame_valid),
        .test_end        (test_end),
        .exp_frame_valid (exp_frame_valid),
        .xfer_count      (xfer_count),
        .error_count     (error_count)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // One clock, then the strip's ready a little after the edge
    task automatic step();
        @(posedge clk);
        #1;
        test_end = 1'b0;
        if (hold_ready) begin
            color_ready = 1'b0;
        end else begin
            color_ready = ($urandom % 32'd4) != 32'd0;
        end
    endtask

    task automatic write_host(input int addr, input int color);
        int waited;
        waited     = 0;
        host_valid = 1'b1;
        host_addr  = INDEX_WIDTH'(addr);
        host_color = led_calib_pkg::color_width'(color);
        #1;
        while (!host_ready && !timed_out) begin
            step();
            #1;
            waited++;
            if (waited > WAIT_LIMIT) begin
                $display("Timeout: host write to address %0d was never accepted", addr);
                timed_out = 1'b1;
            end
        end
        step();
        host_valid = 1'b0;
    endtask

    // Settings change only while a colour is held, so no item mixes two settings
    task automatic change_settings(input int new_mode, input int new_bit);
        int waited;
        waited     = 0;
        hold_ready = 1'b1;
        step();
        while (!color_valid && !timed_out) begin
            step();
            waited++;
            if (waited > WAIT_LIMIT) begin
                $display("Timeout: no colour output appeared before a settings change");
                timed_out = 1'b1;
            end
        end
        step();
        mode       = led_calib_pkg::display_mode_e'(new_mode);
        bit_sel    = INDEX_WIDTH'(new_bit);
        hold_ready = 1'b0;
    endtask

    task automatic run_frames(input int frames);
        int zeros;
        int waited;
        zeros  = 0;
        waited = 0;
        while (zeros < frames && !timed_out) begin
            step();
            if (color_valid && color_ready && color_index == '0) begin
                zeros++;
            end
            waited++;
            if (waited > frames * NUM_LEDS * CYCLES_PER_LED) begin
                $display("Timeout: index 0 came out only %0d of %0d times", zeros, frames);
                timed_out = 1'b1;
            end
        end
    endtask

    initial begin
        string line;
        string name;
        int    fd;
        int    code;
        int    a;
        int    b;
        int    tests;
        int    errors_before;
        int    xfers_before;

        tests = 0;
        void'($urandom(26));
        rst             = 1'b1;
        mode            = led_calib_pkg::MODE_OFF;
        bit_sel         = '0;
        host_valid      = 1'b0;
        host_addr       = '0;
        host_color      = '0;
        color_ready     = 1'b0;
        test_end        = 1'b0;
        exp_frame_valid = 1'b0;
        hold_ready      = 1'b0;
        timed_out       = 1'b0;
        file_error      = 1'b0;
        step();
        step();
        rst = 1'b0;

        fd = $fopen("test/led_calib_testdata.txt", "r");
        if (fd == 0) begin
            $display("Could not open the test data file");
            file_error = 1'b1;
        end else begin
            while (!timed_out && !file_error && $fgets(line, fd) > 0) begin
                if (line.len() < 2 || line[0] == "#") begin
                    continue;
                end
                case (line[0])
                    "W": begin
                        code = $sscanf(line, "W %h %h", a, b);
                        if (code != 2) begin
                            $display("Malformed host write in the test data: %s", line);
                            file_error = 1'b1;
                        end else begin
                            write_host(a, b);
                        end
                    end
                    "S": begin
                        code = $sscanf(line, "S %d %d", a, b);
                        if (code != 2) begin
                            $display("Malformed settings line in the test data: %s", line);
                            file_error = 1'b1;
                        end else begin
                            change_settings(a, b);
                        end
                    end
                    "R": begin
                        code = $sscanf(line, "R %s %d %d", name, a, b);
                        if (code != 3) begin
                            $display("Malformed run line in the test data: %s", line);
                            file_error = 1'b1;
                        end else begin
                            errors_before = error_count;
                            xfers_before  = xfer_count;
                            run_frames(a);
                            exp_frame_valid = b[0];
                            test_end        = 1'b1;
                            step();
                            tests++;
                            $display("test %s: %0d transfers, %0d errors", name,
                                     xfer_count - xfers_before,
                                     error_count - errors_before);
                        end
                    end
                    default: begin
                        $display("Unknown command in the test data: %s", line);
                        file_error = 1'b1;
                    end
                endcase
            end
            $fclose(fd);
        end

        $display("%0d tests, %0d transfers, %0d errors", tests, xfer_count, error_count);
        if (error_count == 0 && !timed_out && !file_error) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

/* test/led_calib_testdata.txt */
# W <addr hex> <colour hex>   host write into the frame memory
# S <mode> <bit_sel>          mode 0 index bits, 1 stored, 2 off
# R <name> <index 0 passes> <frame_valid expected at the end>
S 0 1
R frame_valid_early 1 0
R frame_valid_late 2 1
S 0 0
R id_bit0 3 1
S 0 3
R id_bit3 3 1
S 0 5
R id_bit5 3 1
S 1 0
R stored_empty 3 1
W 00 123456
W 05 00ff00
W 31 abcdef
R stored_written 2 1
W 0a 0f0f0f
W 05 ff00ff
W 31 00a0b0
R stored_rewrite 3 1
S 2 0
R off_backpressure 3 1
